// File: hw/core_cfg_pkg.sv
// Game identifiers, download indices, option bit positions and blanking points
package core_cfg_pkg;

	////////////////////
	// Game selection
	////////////////////

	typedef enum logic [7:0] {
		game_robotron = 8'd0,
		game_joust    = 8'd1,
		game_splat    = 8'd2,
		game_bubbles  = 8'd3,
		game_stargate = 8'd4,
		game_alienar  = 8'd5,
		game_sinistar = 8'd6,
		game_playball = 8'd7
	} game_id_t;

	////////////////////
	// Download channel
	////////////////////

	// Index byte that tags each download write
	localparam logic [7:0] dl_index_game = 8'd1;
	localparam logic [7:0] dl_index_dip  = 8'd254;

	// DIP bank depth, only entry 0 reaches the board
	localparam int dip_count      = 8;
	localparam int dip_addr_width = $clog2(dip_count);

	////////////////////
	// Options word
	////////////////////

	localparam int opt_horz_bit      = 2;
	localparam int opt_fire_mode_bit = 6;
	localparam int opt_control_bit   = 7;

	////////////////////
	// Video timing
	////////////////////

	// Horizontal points count half pixels, vertical points count lines
	localparam int hblank_start  = 336;
	localparam int hblank_end    = 40;
	localparam int vblank_start  = 254;
	localparam int vblank_end    = 14;
	localparam int counter_width = 11;

endpackage

// File: hw/io_map_pkg.sv
// Player control struct, cabinet port union, cabinet output and analog axes types
package io_map_pkg;

	////////////////////
	// Player side
	////////////////////

	// One player's controls, all active high
	typedef struct packed {
		logic pause;
		logic autoup;
		logic advance;
		logic coin;
		logic start2;
		logic start1;
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} player_ctrl_t;

	// Raw analog stick, x in the low byte
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} analog_axes_t;

	////////////////////
	// Cabinet side
	////////////////////

	// Digital view of a port byte
	typedef struct packed {
		logic [3:0] action;
		logic [3:0] move;
	} port_digital_t;

	// Space shooter reads the same byte as two stick positions
	typedef struct packed {
		logic [3:0] stick_x;
		logic [3:0] stick_y;
	} port_analog_t;

	typedef union packed {
		port_digital_t digital;
		port_analog_t  analog;
	} cabinet_port_t;

	// Everything the game board samples from the input side
	typedef struct packed {
		cabinet_port_t ja;
		cabinet_port_t jb;
		logic [2:0]    btn;
		logic [7:0]    sw;
		logic          blitter_sc2;
		logic          sinistar;
	} cabinet_out_t;

endpackage

// File: hw/core_config_regs.sv
// Game select and DIP switch registers loaded by the download write strobe
`timescale 1ns/1ps

module core_config_regs
	import core_cfg_pkg::*;
(
	input  logic        clk_sys,
	input  logic        arst_n,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	output game_id_t    game,
	output logic [7:0]  dip
);

	logic [7:0] dip_bank [dip_count];
	logic       game_wr;
	logic       dip_wr;

	assign game_wr = dl_wr && (dl_index == dl_index_game);

	// Addresses past the bank are ignored
	assign dip_wr = dl_wr && (dl_index == dl_index_dip) && (dl_addr < 25'(dip_count));

	////////////////////
	// Game select
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			game <= game_robotron;
		else if (game_wr)
			game <= game_id_t'(dl_data);
	end

	////////////////////
	// DIP bank
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < dip_count; i++)
				dip_bank[i] <= 8'h00;
		end
		else if (dip_wr)
		begin
			dip_bank[dl_addr[dip_addr_width-1:0]] <= dl_data;
		end
	end

	// Board switch byte
	assign dip = dip_bank[0];

endmodule

// File: hw/stick_quantizer.sv
// Threshold table from a signed analog stick to 4-bit cabinet stick positions
`timescale 1ns/1ps

module stick_quantizer
	import io_map_pkg::*;
(
	input  analog_axes_t  axes,
	output cabinet_port_t pos
);

	// Horizontal axis, full left is 0
	always_comb
	begin
		if (axes.x < -8'sd96)
			pos.analog.stick_x = 4'd0;
		else if (axes.x < -8'sd64)
			pos.analog.stick_x = 4'd4;
		else if (axes.x < -8'sd32)
			pos.analog.stick_x = 4'd6;
		else if (axes.x > 8'sd96)
			pos.analog.stick_x = 4'd8;
		else if (axes.x > 8'sd64)
			pos.analog.stick_x = 4'd9;
		else if (axes.x > 8'sd32)
			pos.analog.stick_x = 4'd11;
		else
			pos.analog.stick_x = 4'd7;
	end

	// Vertical axis runs the other way, stick up is negative
	always_comb
	begin
		if (axes.y < -8'sd96)
			pos.analog.stick_y = 4'd8;
		else if (axes.y < -8'sd64)
			pos.analog.stick_y = 4'd9;
		else if (axes.y < -8'sd32)
			pos.analog.stick_y = 4'd11;
		else if (axes.y > 8'sd96)
			pos.analog.stick_y = 4'd0;
		else if (axes.y > 8'sd64)
			pos.analog.stick_y = 4'd4;
		else if (axes.y > 8'sd32)
			pos.analog.stick_y = 4'd6;
		else
			pos.analog.stick_y = 4'd7;
	end

endmodule

// File: hw/control_mapper.sv
// Per-game mapping of both players' controls onto the registered cabinet ports
`timescale 1ns/1ps

module control_mapper
	import core_cfg_pkg::*;
	import io_map_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  game_id_t     game,
	input  logic [7:0]   dip,
	input  logic [31:0]  options,
	input  player_ctrl_t p1,
	input  player_ctrl_t p2,
	input  analog_axes_t a1,
	input  analog_axes_t a2,
	input  logic         ship_facing,
	output cabinet_out_t cab
);

	player_ctrl_t  pm;
	logic          use_a2;
	analog_axes_t  axes_sel;
	cabinet_port_t quant;
	cabinet_out_t  cab_next;
	logic          fire_mode;
	logic          ctrl_mode;
	logic          sg_fire_e;

	// Joystick nibble in board order
	function automatic logic [3:0] move_of(input player_ctrl_t p);
		return {p.right, p.left, p.down, p.up};
	endfunction

	// Four-way fire nibble
	function automatic logic [3:0] fire_of(input player_ctrl_t p);
		return {p.fire_a, p.fire_d, p.fire_b, p.fire_c};
	endfunction

	assign pm = player_ctrl_t'(p1 | p2);

	assign fire_mode = options[opt_fire_mode_bit];
	assign ctrl_mode = options[opt_control_bit];
	assign sg_fire_e = {options[opt_control_bit], options[opt_fire_mode_bit]} == 2'b10;

	////////////////////
	// Analog stick
	////////////////////

	// Last player to touch anything owns the analog stick
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			use_a2 <= 1'b0;
		else if (p1 != '0)
			use_a2 <= 1'b0;
		else if (p2 != '0)
			use_a2 <= 1'b1;
	end

	assign axes_sel = use_a2 ? a2 : a1;

	stick_quantizer u_stick_quantizer (
		.axes (axes_sel),
		.pos  (quant)
	);

	////////////////////
	// Game mapping
	////////////////////

	always_comb
	begin
		cabinet_port_t ja_h;
		cabinet_port_t jb_h;

		// Active high here, flipped at the end
		ja_h = '0;
		jb_h = '0;
		cab_next = '0;
		cab_next.sw = dip | {6'b0, pm.advance, pm.autoup};

		case (game)
			game_robotron:
			begin
				cab_next.btn = {pm.start1, pm.start2, pm.coin};
				if (ctrl_mode)
				begin
					// Twin stick cabinet, fire stick is player 2
					ja_h.digital.action = move_of(p2);
					ja_h.digital.move = move_of(p1);
				end
				else
				begin
					ja_h.digital.action = fire_mode ? move_of(pm) : fire_of(pm);
					ja_h.digital.move = move_of(pm);
				end
				jb_h = ja_h;
			end
			game_joust:
			begin
				cab_next.btn = {pm.start2, pm.start1, pm.coin};
				ja_h = {5'b0, p1.fire_a, p1.right, p1.left};
				jb_h = {5'b0, p2.fire_a, p2.right, p2.left};
			end
			game_splat:
			begin
				cab_next.blitter_sc2 = 1'b1;
				cab_next.btn = {pm.start1, pm.start2, pm.coin};
				ja_h.digital.action = fire_mode ? move_of(p1) : fire_of(p1);
				ja_h.digital.move = move_of(p1);
				jb_h.digital.action = fire_mode ? move_of(p2) : fire_of(p2);
				jb_h.digital.move = move_of(p2);
			end
			game_bubbles:
			begin
				cab_next.btn = {pm.start2, pm.start1, pm.coin};
				ja_h.digital.move = move_of(pm);
				jb_h = ja_h;
			end
			game_stargate:
			begin
				cab_next.btn = {pm.start2, pm.start1, pm.coin};
				ja_h[7:6] = {pm.fire_f, pm.up};
				ja_h[5] = pm.down;
				ja_h[3:2] = {pm.fire_d, pm.fire_c};
				ja_h[0] = pm.fire_a;
				// Reverse and thrust slots
				if (sg_fire_e)
				begin
					ja_h[4] = pm.fire_e;
					ja_h[1] = pm.fire_b;
				end
				else if (fire_mode)
				begin
					ja_h[4] = ship_facing ? pm.right : pm.left;
					ja_h[1] = ship_facing ? pm.left : pm.right;
				end
				else
				begin
					ja_h[4] = pm.left | pm.right;
					ja_h[1] = pm.fire_b;
				end
				jb_h = ja_h;
			end
			game_alienar:
			begin
				cab_next.btn = {pm.start1, pm.start2, pm.coin};
				ja_h = {2'b0, p1.fire_b, p1.fire_a, move_of(p1)};
				jb_h = {2'b0, p2.fire_b, p2.fire_a, move_of(p2)};
			end
			game_sinistar:
			begin
				cab_next.sinistar = 1'b1;
				cab_next.btn = {pm.start1, pm.start2, pm.coin};
				// Centered analog falls back to the digital stick
				if (quant.analog.stick_x != 4'd7)
					ja_h.analog.stick_x = quant.analog.stick_x;
				else
					ja_h.analog.stick_x = pm.left ? 4'd0 : (pm.right ? 4'd8 : 4'd7);
				if (quant.analog.stick_y != 4'd7)
					ja_h.analog.stick_y = quant.analog.stick_y;
				else
					ja_h.analog.stick_y = pm.down ? 4'd0 : (pm.up ? 4'd8 : 4'd7);
				jb_h = ja_h;
			end
			game_playball:
			begin
				cab_next.btn = {2'b00, pm.coin};
				ja_h = {4'b0, pm.start2, pm.right, pm.left, pm.start1};
				jb_h = ja_h;
			end
			default:
			begin
				// Unknown game leaves every port idle
			end
		endcase

		cab_next.ja = ~ja_h;
		cab_next.jb = ~jb_h;
	end

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cab <= '0;
			cab.ja <= 8'hFF;
			cab.jb <= 8'hFF;
		end
		else
		begin
			cab <= cab_next;
		end
	end

endmodule

// File: hw/video_blank_gen.sv
// Pixel and line counters driven by board sync, giving pixel enable and blanking
`timescale 1ns/1ps

module video_blank_gen
	import core_cfg_pkg::*;
(
	input  logic clk_sys,
	input  logic arst_n,
	input  logic hsync,
	input  logic vsync,
	output logic ce_pix,
	output logic hblank,
	output logic vblank
);

	logic [counter_width-1:0] pix_cnt;
	logic [counter_width-1:0] line_cnt;
	logic                     hsync_d;
	logic                     vsync_line;
	logic                     hsync_rise;

	assign hsync_rise = hsync & ~hsync_d;

	////////////////////
	// Counters
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix_cnt <= '0;
			line_cnt <= '0;
			hsync_d <= 1'b0;
			vsync_line <= 1'b0;
		end
		else
		begin
			hsync_d <= hsync;
			if (~&pix_cnt)
				pix_cnt <= pix_cnt + 1'b1;
			if (hsync_rise)
			begin
				pix_cnt <= '0;
				if (~&line_cnt)
					line_cnt <= line_cnt + 1'b1;
				// vsync is only looked at on line boundaries
				vsync_line <= vsync;
				if (vsync & ~vsync_line)
					line_cnt <= '0;
			end
		end
	end

	// Board pixel rate is half the system clock
	assign ce_pix = pix_cnt[0];

	////////////////////
	// Blanking
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			if (pix_cnt[counter_width-1:1] == (counter_width-1)'(hblank_start))
				hblank <= 1'b1;
			if (pix_cnt[counter_width-1:1] == (counter_width-1)'(hblank_end))
				hblank <= 1'b0;
			if (line_cnt == counter_width'(vblank_start))
				vblank <= 1'b1;
			if (line_cnt == counter_width'(vblank_end))
				vblank <= 1'b0;
		end
	end

endmodule

// File: hw/robotron_io_top.sv
// Board interface top with configuration registers, control mapper and blank generator
`timescale 1ns/1ps

module robotron_io_top
	import core_cfg_pkg::*;
	import io_map_pkg::*;
(
	input  logic         clk_sys,
	input  logic         arst_n,
	input  logic         dl_wr,
	input  logic [7:0]   dl_index,
	input  logic [24:0]  dl_addr,
	input  logic [7:0]   dl_data,
	input  logic [31:0]  options,
	input  player_ctrl_t p1,
	input  player_ctrl_t p2,
	input  analog_axes_t a1,
	input  analog_axes_t a2,
	input  logic         ship_facing,
	input  logic         hsync,
	input  logic         vsync,
	output cabinet_out_t cab,
	output logic         ce_pix,
	output logic         hblank,
	output logic         vblank
);

	game_id_t   game;
	logic [7:0] dip;

	////////////////////
	// Input side
	////////////////////

	core_config_regs u_core_config_regs (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl_wr    (dl_wr),
		.dl_index (dl_index),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.game     (game),
		.dip      (dip)
	);

	control_mapper u_control_mapper (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.game        (game),
		.dip         (dip),
		.options     (options),
		.p1          (p1),
		.p2          (p2),
		.a1          (a1),
		.a2          (a2),
		.ship_facing (ship_facing),
		.cab         (cab)
	);

	////////////////////
	// Video side
	////////////////////

	video_blank_gen u_video_blank_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.hsync   (hsync),
		.vsync   (vsync),
		.ce_pix  (ce_pix),
		.hblank  (hblank),
		.vblank  (vblank)
	);

endmodule

// File: test/robotron_io_properties.sv
// Bound assertions on cabinet port reset values and horizontal blanking points
`timescale 1ns/1ps

module robotron_io_properties
	import core_cfg_pkg::*;
	import io_map_pkg::*;
(
	input logic                     clk_sys,
	input logic                     arst_n,
	input cabinet_out_t             cab,
	input logic [counter_width-1:0] pix_cnt,
	input logic                     hblank
);

	// Ports idle high and no buttons while reset is held
	ports_idle_in_reset: assert property (@(posedge clk_sys)
		!arst_n |-> (cab.ja == 8'hFF && cab.jb == 8'hFF && cab.btn == 3'b000))
		else $error("cabinet ports not idle during reset");

	// hblank goes high only right after the count passes the start point
	hblank_rise_point: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(hblank) |->
			$past(pix_cnt[counter_width-1:1]) == (counter_width-1)'(hblank_start))
		else $error("hblank rose away from the start point");

	hblank_fall_point: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(hblank) |->
			$past(pix_cnt[counter_width-1:1]) == (counter_width-1)'(hblank_end))
		else $error("hblank fell away from the end point");

endmodule

// Cabinet output comes from the mapper, pixel count from the blank generator
bind robotron_io_top robotron_io_properties u_robotron_io_properties (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.cab     (cab),
	.pix_cnt (u_video_blank_gen.pix_cnt),
	.hblank  (hblank)
);

// File: test/tb_robotron_io.sv
// Testbench with table driven control mapping, DIP, analog stick and blanking checks
`timescale 1ns/1ps

module tb_robotron_io
	import core_cfg_pkg::*;
	import io_map_pkg::*;
();

	localparam int line_clocks  = 800;
	localparam int frame_lines  = 280;
	localparam int hsync_width  = 64;
	localparam int vsync_lines  = 3;
	localparam int frame_clocks = line_clocks * frame_lines;

	localparam player_ctrl_t pc0       = '0;
	localparam player_ctrl_t pc_right  = '{right: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_left   = '{left: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_down   = '{down: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_up     = '{up: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_fa     = '{fire_a: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_fb     = '{fire_b: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_fd     = '{fire_d: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_fe     = '{fire_e: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_start1 = '{start1: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_start2 = '{start2: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_coin   = '{coin: 1'b1, default: 1'b0};
	localparam player_ctrl_t pc_adv    = '{advance: 1'b1, default: 1'b0};
	localparam analog_axes_t ax0       = '0;
	localparam analog_axes_t axf       = '{x: 8'sd100, y: -8'sd100};

	// One mapping case with its expected active low ports
	typedef struct packed {
		game_id_t     game;
		logic [31:0]  options;
		player_ctrl_t p1;
		player_ctrl_t p2;
		analog_axes_t a1;
		analog_axes_t a2;
		logic         facing;
		logic [7:0]   ja;
		logic [7:0]   jb;
		logic [2:0]   btn;
	} map_row_t;

	logic         clk_sys;
	logic         arst_n;
	logic         dl_wr;
	logic [7:0]   dl_index;
	logic [24:0]  dl_addr;
	logic [7:0]   dl_data;
	logic [31:0]  options;
	player_ctrl_t p1;
	player_ctrl_t p2;
	analog_axes_t a1;
	analog_axes_t a2;
	logic         ship_facing;
	logic         hsync;
	logic         vsync;
	cabinet_out_t cab;
	logic         ce_pix;
	logic         hblank;
	logic         vblank;
	map_row_t     rows[$];
	logic         sync_run;
	int           h_pos;
	int           v_line;

	robotron_io_top DUT (.*);

	always #50 clk_sys = ~clk_sys;

	////////////////////
	// Sync generator
	////////////////////

	// h_pos and v_line hold the position being driven
	always @(posedge clk_sys)
	begin
		#1;
		if (sync_run)
		begin
			if (h_pos == line_clocks - 1)
			begin
				h_pos = 0;
				v_line = (v_line == frame_lines - 1) ? 0 : v_line + 1;
			end
			else
				h_pos = h_pos + 1;
			hsync = (h_pos < hsync_width);
			vsync = (v_line < vsync_lines);
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
				name, got, expected));
	endtask

	task automatic step_clock();
		@(posedge clk_sys);
		#1;
	endtask

	// Single cycle download write, returns with the strobe low again
	task automatic write_cfg(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		dl_wr = 1'b1;
		dl_index = index;
		dl_addr = addr;
		dl_data = data;
		step_clock();
		dl_wr = 1'b0;
	endtask

	task automatic await_vblank(input logic level, input int limit);
		int n;
		n = 0;
		while (vblank !== level && n < limit)
		begin
			@(negedge clk_sys);
			n++;
		end
		if (vblank !== level)
			stop_on_error($sformatf("timeout waiting for vblank to reach %0b", level));
	endtask

	task automatic add_row(input game_id_t g, input logic [31:0] opt,
		input player_ctrl_t q1, input player_ctrl_t q2, input analog_axes_t x1,
		input analog_axes_t x2, input logic facing, input logic [7:0] e_ja,
		input logic [7:0] e_jb, input logic [2:0] e_btn);
		map_row_t r;
		r = '{g, opt, q1, q2, x1, x2, facing, e_ja, e_jb, e_btn};
		rows.push_back(r);
	endtask

	// Stick position bands, y is fed in negated
	function automatic logic [3:0] stick_code(input int v);
		if (v < -96)
			return 4'd0;
		if (v < -64)
			return 4'd4;
		if (v < -32)
			return 4'd6;
		if (v > 96)
			return 4'd8;
		if (v > 64)
			return 4'd9;
		if (v > 32)
			return 4'd11;
		return 4'd7;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		map_row_t r;
		logic [31:0] rnd;
		logic [3:0] exp_x;
		logic [3:0] exp_y;
		int half;

		void'($urandom(32'h19f46af8));
		clk_sys = 1'b0;
		arst_n = 1'b1;
		dl_wr = 1'b0;
		dl_index = 8'h00;
		dl_addr = '0;
		dl_data = 8'h00;
		options = '0;
		p1 = pc0;
		p2 = pc0;
		a1 = ax0;
		a2 = ax0;
		ship_facing = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		sync_run = 1'b0;
		h_pos = line_clocks - 1;
		v_line = frame_lines - 1;

		add_row(game_robotron, 32'h00, pc_right, pc0, ax0, ax0, 0, 8'hF7, 8'hF7, 3'b000);
		add_row(game_robotron, 32'h00, pc_fa, pc0, ax0, ax0, 0, 8'h7F, 8'h7F, 3'b000);
		add_row(game_robotron, 32'h00, pc0, pc_start1, ax0, ax0, 0, 8'hFF, 8'hFF, 3'b100);
		add_row(game_robotron, 32'h40, pc_up, pc0, ax0, ax0, 0, 8'hEE, 8'hEE, 3'b000);
		add_row(game_robotron, 32'h80, pc_left, pc_down, ax0, ax0, 0, 8'hDB, 8'hDB, 3'b000);
		add_row(game_joust, 32'h00, pc_fa | pc_coin, pc_left, ax0, ax0, 0, 8'hFB, 8'hFE, 3'b001);
		add_row(game_joust, 32'h00, pc0, pc_start2, ax0, ax0, 0, 8'hFF, 8'hFF, 3'b100);
		add_row(game_splat, 32'h00, pc_fb, pc_up, ax0, ax0, 0, 8'hDF, 8'hFE, 3'b000);
		add_row(game_splat, 32'h40, pc_right, pc0, ax0, ax0, 0, 8'h77, 8'hFF, 3'b000);
		add_row(game_bubbles, 32'h00, pc_start1, pc_down, ax0, ax0, 0, 8'hFD, 8'hFD, 3'b010);
		add_row(game_stargate, 32'h00, pc_up, pc0, ax0, ax0, 0, 8'hBF, 8'hBF, 3'b000);
		add_row(game_stargate, 32'h00, pc_left, pc0, ax0, ax0, 0, 8'hEF, 8'hEF, 3'b000);
		add_row(game_stargate, 32'h00, pc_fb, pc0, ax0, ax0, 0, 8'hFD, 8'hFD, 3'b000);
		add_row(game_stargate, 32'h00, pc_fd, pc0, ax0, ax0, 0, 8'hF7, 8'hF7, 3'b000);
		add_row(game_stargate, 32'h80, pc_fe | pc_left, pc0, ax0, ax0, 0, 8'hEF, 8'hEF, 3'b000);
		add_row(game_stargate, 32'h40, pc_left, pc0, ax0, ax0, 0, 8'hEF, 8'hEF, 3'b000);
		add_row(game_stargate, 32'h40, pc_left, pc0, ax0, ax0, 1, 8'hFD, 8'hFD, 3'b000);
		add_row(game_stargate, 32'h40, pc_right, pc0, ax0, ax0, 0, 8'hFD, 8'hFD, 3'b000);
		add_row(game_stargate, 32'h40, pc_right, pc0, ax0, ax0, 1, 8'hEF, 8'hEF, 3'b000);
		add_row(game_alienar, 32'h00, pc_fb, pc_fa, ax0, ax0, 0, 8'hDF, 8'hEF, 3'b000);
		add_row(game_alienar, 32'h00, pc_up | pc_coin, pc_right, ax0, ax0, 0, 8'hFE, 8'hF7, 3'b001);
		add_row(game_sinistar, 32'h00, pc0, pc0, ax0, ax0, 0, 8'h88, 8'h88, 3'b000);
		add_row(game_sinistar, 32'h00, pc_left | pc_up, pc0, ax0, ax0, 0, 8'hF7, 8'hF7, 3'b000);
		add_row(game_sinistar, 32'h00, pc_right | pc_down, pc0, ax0, ax0, 0, 8'h7F, 8'h7F, 3'b000);
		// p2 activity hands the stick over to a2
		add_row(game_sinistar, 32'h00, pc0, pc_start2, ax0, axf, 0, 8'h77, 8'h77, 3'b010);
		add_row(game_playball, 32'h00, pc_coin, pc0, ax0, ax0, 0, 8'hFF, 8'hFF, 3'b001);
		add_row(game_playball, 32'h00, pc_start1, pc_right, ax0, ax0, 0, 8'hFA, 8'hFA, 3'b000);

		// Reset for ten clocks
		#1;
		arst_n = 1'b0;
		repeat (10) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;

		// Reset values
		check_value("cab.ja", cab.ja, 8'hFF);
		check_value("cab.jb", cab.jb, 8'hFF);
		check_value("cab.btn", cab.btn, 3'b000);
		check_value("hblank", hblank, 1'b0);
		check_value("vblank", vblank, 1'b0);

		// Game write lands one cycle later, cab one more
		for (int i = 0; i < rows.size(); i++)
		begin
			r = rows[i];
			options = r.options;
			p1 = r.p1;
			p2 = r.p2;
			a1 = r.a1;
			a2 = r.a2;
			ship_facing = r.facing;
			write_cfg(dl_index_game, 25'd0, r.game);
			step_clock();
			check_value($sformatf("row %0d cab.ja", i), cab.ja, r.ja);
			check_value($sformatf("row %0d cab.jb", i), cab.jb, r.jb);
			check_value($sformatf("row %0d cab.btn", i), cab.btn, r.btn);
			check_value($sformatf("row %0d cab.blitter_sc2", i), cab.blitter_sc2,
				r.game == game_splat);
			check_value($sformatf("row %0d cab.sinistar", i), cab.sinistar,
				r.game == game_sinistar);
		end

		// DIP bank, only entry 0 reaches sw
		options = '0;
		p1 = pc0;
		p2 = pc0;
		write_cfg(dl_index_dip, 25'd0, 8'hA4);
		p1 = pc_adv;
		step_clock();
		check_value("cab.sw", cab.sw, 8'hA6);
		write_cfg(dl_index_dip, 25'd5, 8'h5B);
		step_clock();
		check_value("cab.sw", cab.sw, 8'hA6);

		// Analog stick from a1 after player 1 activity
		p1 = pc_coin;
		a2 = axf;
		write_cfg(dl_index_game, 25'd0, game_sinistar);
		p1 = pc0;
		step_clock();
		repeat (24)
		begin
			rnd = $urandom;
			a1 = rnd[15:0];
			step_clock();
			// Port positions are active low
			exp_x = ~stick_code(int'(a1.x));
			exp_y = ~stick_code(-int'(a1.y));
			check_value("cab.ja.stick_x", cab.ja.analog.stick_x, exp_x);
			check_value("cab.ja.stick_y", cab.ja.analog.stick_y, exp_y);
		end

		////////////////////
		// Blanking
		////////////////////

		@(negedge clk_sys);
		sync_run = 1'b1;
		// First frame lines up the line counter
		await_vblank(1'b1, 2 * frame_clocks);
		await_vblank(1'b0, 2 * frame_clocks);
		repeat (frame_clocks)
		begin
			@(negedge clk_sys);
			half = h_pos / 2;
			// Pixel count trails the driven position by one clock
			check_value("ce_pix", ce_pix, ((h_pos + line_clocks - 1) % line_clocks) % 2);
			if ((half < hblank_start - 3 || half > hblank_start + 3) &&
				(half < hblank_end - 3 || half > hblank_end + 3))
				check_value("hblank", hblank, (half >= hblank_start || half < hblank_end));
			if (h_pos >= 8)
				check_value("vblank", vblank, (v_line >= vblank_start || v_line < vblank_end));
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: robotron_io.f
hw/core_cfg_pkg.sv
hw/io_map_pkg.sv
hw/core_config_regs.sv
hw/stick_quantizer.sv
hw/control_mapper.sv
hw/video_blank_gen.sv
hw/robotron_io_top.sv
test/robotron_io_properties.sv
test/tb_robotron_io.sv

// File: Bender.yml
package:
  name: robotron_io

sources:
  # Packages first, the modules import them
  - hw/core_cfg_pkg.sv
  - hw/io_map_pkg.sv
  - hw/core_config_regs.sv
  - hw/stick_quantizer.sv
  - hw/control_mapper.sv
  - hw/video_blank_gen.sv
  - hw/robotron_io_top.sv

  - target: test
    files:
      - test/robotron_io_properties.sv
      - test/tb_robotron_io.sv
